/* dii_pkg.sv */
// Debug interconnect flit type, packet-length limit and packet size type
package dii_pkg;

   // Width of the data field carried by one flit
   localparam int flit_data_w = 16;

   // Largest number of flits in one debug packet
   localparam int max_pkt_len = 16;

   // A packet size must be able to hold max_pkt_len itself, not just max_pkt_len - 1
   localparam int pkt_size_w = $clog2(max_pkt_len + 1);

   // Unsigned flit count of one packet, 1 to max_pkt_len in normal use
   typedef logic [pkt_size_w-1:0] pkt_size_t;

   // One flit on the debug interconnect
   //
   // The valid bit qualifies the whole flit. The last bit is set on the final
   // flit of a packet and is meaningless while valid is low.
   typedef struct packed {
      logic [flit_data_w-1:0] data;
      logic                   valid;
      logic                   last;
   } dii_flit;

   // Empty flit, useful as an idle value on a link
   localparam dii_flit flit_idle = '{data: '0, valid: 1'b0, last: 1'b0};

endpackage

/* glip_pkg.sv */
// Host-link word union, length header struct and host-link stream struct
package glip_pkg;

   // Width of one word on the host link
   localparam int glip_word_w = 16;

   // The low bits of a header word carry the payload length
   localparam int glip_len_w = 5;

   // Everything above the length field is reserved and sent as zero
   localparam int glip_rsvd_w = glip_word_w - glip_len_w;

   // Header view of a host word, length in the low five bits
   typedef struct packed {
      logic [glip_rsvd_w-1:0] rsvd;
      logic [glip_len_w-1:0]  len;
   } glip_hdr_t;

   // The same host word is either a length header or raw payload,
   // depending on where it sits in the packet
   typedef union packed {
      logic [glip_word_w-1:0] raw;
      glip_hdr_t              hdr;
   } glip_word_u;

   // Host-link data and its valid bit in one direction
   //
   // Ready travels the other way and is a separate port on each module.
   typedef struct packed {
      glip_word_u data;
      logic       valid;
   } glip_stream_t;

   // Idle value for a host-link stream
   localparam glip_stream_t glip_idle = '{data: '0, valid: 1'b0};

endpackage

/* pkt_deframer.sv */
// Ingress deframer that strips the length word and turns host payload into flits
module pkt_deframer (
   input  logic                   clk,
   input  logic                   rst,
   input  glip_pkg::glip_stream_t host_in,
   output logic                   host_in_ready,
   output dii_pkg::dii_flit       flit_out,
   input  logic                   flit_out_ready
);
   import dii_pkg::*;
   import glip_pkg::*;

   // Set between an accepted header and the last payload word of its packet
   logic      active;

   // Payload words still to come after the current one
   logic      [glip_len_w-1:0] len_field;
   pkt_size_t remaining;

   glip_word_u word;
   logic       host_xfer;

   assign word      = host_in.data;
   assign len_field = word.hdr.len;
   assign host_xfer = host_in.valid & host_in_ready;

   // A header is always taken while idle, payload only when the buffer can take it
   assign host_in_ready = !active | flit_out_ready;

   // Payload words go straight through, no register in the path
   assign flit_out.data  = word.raw;
   assign flit_out.valid = active & host_in.valid;
   assign flit_out.last  = active & (remaining == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         active    <= 1'b0;
         remaining <= '0;
      end else if (host_xfer) begin
         if (!active) begin
            // Header word, produces no flit
            remaining <= pkt_size_t'(len_field) - 1'b1;
            active    <= 1'b1;
         end else begin
            remaining <= remaining - 1'b1;
            if (remaining == '0) begin
               active <= 1'b0;
            end
         end
      end
   end

   // Zero-length headers are not supported on the host link
   a_hdr_nonzero: assert property (
      @(posedge clk) disable iff (rst)
      (!active && host_xfer) |-> (len_field != '0)
   ) else $error("deframer accepted a zero-length header");

   // Holds only if the host keeps its word stable, so this also checks the host side
   a_flit_stable: assert property (
      @(posedge clk) disable iff (rst)
      (flit_out.valid && !flit_out_ready) |=> $stable(flit_out)
   ) else $error("deframer changed flit_out while stalled");

endmodule

/* flit_packet_buffer.sv */
// Full-packet flit FIFO that releases a packet only once all of its flits are stored
module flit_packet_buffer #(
   parameter int depth = dii_pkg::max_pkt_len
) (
   input  logic               clk,
   input  logic               rst,
   input  dii_pkg::dii_flit   flit_in,
   output logic               flit_in_ready,
   output dii_pkg::dii_flit   flit_out,
   input  logic               flit_out_ready,
   output dii_pkg::pkt_size_t packet_size
);
   import dii_pkg::*;

   localparam int idx_w = $clog2(depth);
   // One extra pointer bit tells full from empty
   localparam int ptr_w = idx_w + 1;

   typedef logic [ptr_w-1:0] ptr_t;
   typedef logic [idx_w-1:0] idx_t;

   // Flit store, valid is implied by position
   logic [flit_data_w-1:0] data_mem [depth];
   logic                   last_mem [depth];

   // Length of each complete packet in arrival order
   pkt_size_t size_mem [depth];

   ptr_t      wr_ptr;
   ptr_t      rd_ptr;
   ptr_t      fill;
   idx_t      size_wr;
   idx_t      size_rd;
   ptr_t      pkt_count;
   pkt_size_t cur_size;

   logic full;
   logic wr_en;
   logic rd_en;
   logic wr_last;
   logic rd_last;

   assign fill = wr_ptr - rd_ptr;
   assign full = (fill == ptr_t'(depth));

   assign flit_in_ready = !full;
   assign wr_en         = flit_in.valid & flit_in_ready;
   assign wr_last       = wr_en & flit_in.last;

   // Nothing is offered until a whole packet sits in the store
   assign flit_out.valid = (pkt_count != '0);
   assign flit_out.data  = data_mem[rd_ptr[idx_w-1:0]];
   assign flit_out.last  = last_mem[rd_ptr[idx_w-1:0]];
   assign rd_en          = flit_out.valid & flit_out_ready;
   assign rd_last        = rd_en & flit_out.last;

   assign packet_size = size_mem[size_rd];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[wr_ptr[idx_w-1:0]] <= flit_in.data;
         last_mem[wr_ptr[idx_w-1:0]] <= flit_in.last;
      end
      if (wr_last) begin
         size_mem[size_wr] <= cur_size + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         size_wr   <= '0;
         size_rd   <= '0;
         pkt_count <= '0;
         cur_size  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            // Count flits of the packet being written, restart after its last
            if (flit_in.last) begin
               cur_size <= '0;
               size_wr  <= size_wr + 1'b1;
            end else begin
               cur_size <= cur_size + 1'b1;
            end
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (rd_last) begin
            size_rd <= size_rd + 1'b1;
         end
         // A last write and a last read in the same cycle cancel out
         if (wr_last && !rd_last) begin
            pkt_count <= pkt_count + 1'b1;
         end else if (rd_last && !wr_last) begin
            pkt_count <= pkt_count - 1'b1;
         end
      end
   end

   // A full store must hold a whole packet, otherwise nothing could ever drain it
   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst)
      full |-> (pkt_count != '0)
   ) else $error("flit buffer full without a complete packet");

   // The packet count must never claim flits that are not in the store
   a_no_underflow: assert property (
      @(posedge clk) disable iff (rst)
      rd_en |-> (fill != '0)
   ) else $error("flit buffer read while empty");

endmodule

/* pkt_framer.sv */
// Egress framer that sends a length word and then the flits of each packet to the host
module pkt_framer (
   input  logic                   clk,
   input  logic                   rst,
   input  dii_pkg::dii_flit       flit_in,
   output logic                   flit_in_ready,
   input  dii_pkg::pkt_size_t     packet_size,
   output glip_pkg::glip_stream_t host_out,
   input  logic                   host_out_ready
);
   import glip_pkg::*;

   // Set after the header went out, cleared by the accepted last flit
   logic       active;
   glip_word_u word;
   logic       hdr_xfer;
   logic       last_xfer;

   // While idle the header is shown, while active the flit data
   always_comb begin
      word = '0;
      if (!active) begin
         word.hdr.rsvd = '0;
         word.hdr.len  = packet_size;
      end else begin
         word.raw = flit_in.data;
      end
   end

   assign host_out.data  = word;
   // The buffer only raises valid with a whole packet stored, so this also
   // gates the header until the packet is complete
   assign host_out.valid = flit_in.valid;

   // Flits are never taken during the header cycle
   assign flit_in_ready = active & host_out_ready;

   assign hdr_xfer  = !active & flit_in.valid & host_out_ready;
   assign last_xfer = flit_in.valid & flit_in_ready & flit_in.last;

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= 1'b0;
      end else if (!active) begin
         if (hdr_xfer) begin
            active <= 1'b1;
         end
      end else if (last_xfer) begin
         active <= 1'b0;
      end
   end

   // Header and data words both hold while the host stalls
   a_host_stable: assert property (
      @(posedge clk) disable iff (rst)
      (host_out.valid && !host_out_ready) |=> $stable(host_out)
   ) else $error("framer changed host_out while stalled");

   // A header never announces an empty packet
   a_hdr_len: assert property (
      @(posedge clk) disable iff (rst)
      (!active && host_out.valid) |-> (packet_size != '0)
   ) else $error("framer sent a zero-length header");

endmodule

/* host_if_top.sv */
// Host interface top joining the ingress deframer chain and the egress framer chain
module host_if_top (
   input  logic                   clk,
   input  logic                   rst,
   input  glip_pkg::glip_stream_t host_in,
   output logic                   host_in_ready,
   output glip_pkg::glip_stream_t host_out,
   input  logic                   host_out_ready,
   output dii_pkg::dii_flit       net_out,
   input  logic                   net_out_ready,
   input  dii_pkg::dii_flit       net_in,
   output logic                   net_in_ready
);
   import dii_pkg::*;

   // Ingress between deframer and buffer
   dii_flit   ingress_flit;
   logic      ingress_flit_ready;

   // Egress between buffer and framer
   dii_flit   egress_flit;
   logic      egress_flit_ready;
   pkt_size_t egress_pkt_size;

   pkt_deframer u_deframer (
      .clk            (clk),
      .rst            (rst),
      .host_in        (host_in),
      .host_in_ready  (host_in_ready),
      .flit_out       (ingress_flit),
      .flit_out_ready (ingress_flit_ready)
   );

   // Ingress packets are held until complete, the size is not needed downstream
   flit_packet_buffer #(.depth(max_pkt_len)) u_ingress_buffer (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (ingress_flit),
      .flit_in_ready  (ingress_flit_ready),
      .flit_out       (net_out),
      .flit_out_ready (net_out_ready),
      .packet_size    ()
   );

   flit_packet_buffer #(.depth(max_pkt_len)) u_egress_buffer (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (net_in),
      .flit_in_ready  (net_in_ready),
      .flit_out       (egress_flit),
      .flit_out_ready (egress_flit_ready),
      .packet_size    (egress_pkt_size)
   );

   pkt_framer u_framer (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (egress_flit),
      .flit_in_ready  (egress_flit_ready),
      .packet_size    (egress_pkt_size),
      .host_out       (host_out),
      .host_out_ready (host_out_ready)
   );

endmodule

/* tb_host_if.sv */
// Testbench for the host interface with random traffic, model queues, compare tasks and watchdog
module tb_host_if;
   timeunit 1ns;
   timeprecision 1ps;

   import dii_pkg::*;
   import glip_pkg::*;

   localparam int num_pkts     = 60;
   localparam int limit_cycles = 200 * 2 * num_pkts + 1000;
   localparam int drain_cycles = 64;

   logic         clk;
   logic         rst;
   glip_stream_t host_in;
   logic         host_in_ready;
   glip_stream_t host_out;
   logic         host_out_ready;
   dii_flit      net_out;
   logic         net_out_ready;
   dii_flit      net_in;
   logic         net_in_ready;

   // Stimulus still to be sent, with a marker on the last payload word of each packet
   glip_word_u tx_host_q[$];
   bit         tx_host_end_q[$];
   dii_flit    tx_net_q[$];

   // Responses still expected from the DUT
   dii_flit    exp_net_q[$];
   glip_word_u exp_host_q[$];

   logic [31:0] rng_state;
   int          in_pkts_done;
   int          net_pkt_idx;

   host_if_top u_dut (
      .clk            (clk),
      .rst            (rst),
      .host_in        (host_in),
      .host_in_ready  (host_in_ready),
      .host_out       (host_out),
      .host_out_ready (host_out_ready),
      .net_out        (net_out),
      .net_out_ready  (net_out_ready),
      .net_in         (net_in),
      .net_in_ready   (net_in_ready)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // The upper half of an LCG state is far less regular than the lower half
   function logic [15:0] next_rand();
      rng_state = lcg_step(rng_state);
      return rng_state[31:16];
   endfunction

   function logic coin(input int pct);
      int roll;
      roll = int'(next_rand()) % 100;
      return roll < pct;
   endfunction

   task automatic abort_run(input string msg);
      $display("Error at %0d ns: %s", $time, msg);
      $display("*** FAILED ***");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_flit(input dii_flit got, input dii_flit exp, input string what);
      if (got.data !== exp.data || got.last !== exp.last) begin
         $display("[FAIL] %0d ns: %s got data %h last %b, expected data %h last %b",
                  $time, what, got.data, got.last, exp.data, exp.last);
         $display("*** FAILED ***");
         $fatal(1, "Flit mismatch");
      end
   endtask

   task automatic check_word(input glip_word_u got, input glip_word_u exp, input string what);
      if (got.raw !== exp.raw) begin
         $display("[FAIL] %0d ns: %s got %h, expected %h", $time, what, got.raw, exp.raw);
         $display("*** FAILED ***");
         $fatal(1, "Host word mismatch");
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "Control bit mismatch");
      end
   endtask

   // Fills the send queues and the expected queues from the same random draws
   task automatic build_stimulus();
      int         p;
      int         i;
      int         len;
      glip_word_u w;
      dii_flit    f;
      for (p = 0; p < num_pkts; p++) begin
         len = 1 + int'(next_rand()) % max_pkt_len;
         w = '0;
         w.hdr.len = len[glip_len_w-1:0];
         tx_host_q.push_back(w);
         tx_host_end_q.push_back(1'b0);
         for (i = 0; i < len; i++) begin
            w.raw = next_rand();
            tx_host_q.push_back(w);
            tx_host_end_q.push_back(i == len - 1);
            f = '{data: w.raw, valid: 1'b1, last: (i == len - 1)};
            exp_net_q.push_back(f);
         end
         // Egress packet, the header must carry the flit count with reserved bits clear
         len = 1 + int'(next_rand()) % max_pkt_len;
         w = '0;
         w.hdr.len = len[glip_len_w-1:0];
         exp_host_q.push_back(w);
         for (i = 0; i < len; i++) begin
            f = '{data: next_rand(), valid: 1'b1, last: (i == len - 1)};
            tx_net_q.push_back(f);
            w.raw = f.data;
            exp_host_q.push_back(w);
         end
      end
   endtask

   // Uses the values that were stable just before this edge
   task automatic check_outputs();
      dii_flit    exp_f;
      glip_word_u exp_w;
      if (net_out.valid && net_pkt_idx >= in_pkts_done) begin
         abort_run($sformatf("net_out offered a flit of ingress packet %0d %s", net_pkt_idx,
                             "before its last word was accepted on host_in"));
      end
      if (net_out.valid && net_out_ready) begin
         if (exp_net_q.size() == 0) begin
            abort_run("net_out delivered a flit that was never sent");
         end else begin
            exp_f = exp_net_q.pop_front();
            check_flit(net_out, exp_f, "net_out flit");
            if (net_out.last) begin
               net_pkt_idx++;
            end
         end
      end
      if (host_out.valid && host_out_ready) begin
         if (exp_host_q.size() == 0) begin
            abort_run("host_out delivered a word that was never sent");
         end else begin
            exp_w = exp_host_q.pop_front();
            check_word(host_out.data, exp_w, "host_out word");
         end
      end
   endtask

   task automatic drive_inputs(input logic host_xfer, input logic net_xfer);
      glip_stream_t s;
      dii_flit      f;
      // An offered word or flit stays put until it is taken
      if (!host_in.valid || host_xfer) begin
         s = glip_idle;
         if (tx_host_q.size() != 0 && coin(75)) begin
            s.data  = tx_host_q[0];
            s.valid = 1'b1;
         end
         host_in <= s;
      end
      if (!net_in.valid || net_xfer) begin
         f = flit_idle;
         if (tx_net_q.size() != 0 && coin(75)) begin
            f = tx_net_q[0];
         end
         net_in <= f;
      end
      net_out_ready  <= coin(70);
      host_out_ready <= coin(70);
   endtask

   initial begin
      int         drain;
      logic       host_xfer;
      logic       net_xfer;
      bit         word_end;
      rng_state      = 32'h7cd4_dff6;
      in_pkts_done   = 0;
      net_pkt_idx    = 0;
      rst            <= 1'b1;
      host_in        <= glip_idle;
      net_in         <= flit_idle;
      host_out_ready <= 1'b0;
      net_out_ready  <= 1'b0;
      build_stimulus();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_bit(net_out.valid, 1'b0, "net_out valid after reset");
      check_bit(host_out.valid, 1'b0, "host_out valid after reset");
      check_bit(host_in_ready, 1'b1, "host_in_ready after reset");
      check_bit(net_in_ready, 1'b1, "net_in_ready after reset");
      drain = 0;
      while (drain < drain_cycles) begin
         @(posedge clk);
         host_xfer = host_in.valid && host_in_ready;
         net_xfer  = net_in.valid && net_in_ready;
         // Outputs first, so a packet completed at this edge is not yet counted
         check_outputs();
         if (host_xfer) begin
            void'(tx_host_q.pop_front());
            word_end = tx_host_end_q.pop_front();
            if (word_end) begin
               in_pkts_done++;
            end
         end
         if (net_xfer) begin
            void'(tx_net_q.pop_front());
         end
         drive_inputs(host_xfer, net_xfer);
         if (tx_host_q.size() == 0 && tx_net_q.size() == 0 &&
             exp_net_q.size() == 0 && exp_host_q.size() == 0) begin
            drain++;
         end
      end
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("Watchdog: the run did not finish within %0d clock cycles", limit_cycles);
      $display("*** FAILED ***");
      $fatal(1, "Timed out");
   end

endmodule

/* build.f */
dii_pkg.sv
glip_pkg.sv
pkt_deframer.sv
flit_packet_buffer.sv
pkt_framer.sv
host_if_top.sv
tb_host_if.sv

/* run_sim.sh */
#!/bin/sh
# Builds the host interface testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_host_if -f build.f -o sim_host_if

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/sim_host_if > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
   echo "Simulation result: pass"
   exit 0
fi

echo "Simulation result: fail"
exit 1
